/* rtl/rvv_cfg_pkg.sv */
package rvv_cfg_pkg;

    // Vector register file geometry
    localparam int VLEN       = 128;
    localparam int NUM_VREG   = 32;
    localparam int VREG_IDX_W = 5;

    // Instructions the scalar core may hand over per cycle
    localparam int ISSUE_LANE = 2;

    // Queue depths between the stages
    localparam int CQ_DEPTH = 8;
    localparam int RQ_DEPTH = 4;

endpackage

/* rtl/rvv_uop_pkg.sv */
package rvv_uop_pkg;

    import rvv_cfg_pkg::*;

    // Element width of one operation
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } vsew_e;

    // Operations carried out by the ALU
    typedef enum logic [1:0] {
        ALU_ADD   = 2'd0,
        ALU_SUB   = 2'd1,
        ALU_AND   = 2'd2,
        ALU_SADDU = 2'd3
    } alu_op_e;

    // funct6 codes of the OPIVV forms that are supported
    localparam logic [5:0] FUNCT6_VADD   = 6'b000000;
    localparam logic [5:0] FUNCT6_VSUB   = 6'b000010;
    localparam logic [5:0] FUNCT6_VAND   = 6'b001001;
    localparam logic [5:0] FUNCT6_VSADDU = 6'b100000;

    // Instruction word as sent by the scalar core
    typedef struct packed {
        logic [31:0] inst;
        vsew_e       vsew;
    } rvv_cmd_t;

    // Decoded operation with its operands already read
    typedef struct packed {
        alu_op_e                op;
        vsew_e                  vsew;
        logic [VREG_IDX_W-1:0]  vd;
        logic [VLEN-1:0]        vs2_data;
        logic [VLEN-1:0]        vs1_data;
    } rvv_uop_t;

    typedef struct packed {
        logic [VREG_IDX_W-1:0]  vd;
        logic [VLEN-1:0]        data;
        logic                   sat;
    } rvv_result_t;

endpackage

/* rtl/multi_fifo.sv */
module multi_fifo #(
    parameter type T     = logic [7:0],
    parameter int  M     = 1,
    parameter int  N     = 1,
    parameter int  DEPTH = 4
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [M-1:0] push,
    input  T     [M-1:0] data_in,
    input  logic [N-1:0] pop,
    output T     [N-1:0] data_out,
    output logic         full,
    output logic [M-1:1] almost_full,
    output logic         empty,
    output logic [N-1:1] almost_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_cnt;
    logic [CNT_W-1:0] push_cnt;
    logic [CNT_W-1:0] pop_cnt;

    // Slot that lies offset entries after base, around the ring
    function automatic logic [PTR_W-1:0] wrap(logic [PTR_W-1:0] base, int unsigned offset);
        int unsigned idx;
        idx = base + offset;
        return PTR_W'(idx % DEPTH);
    endfunction

    // Lanes are contiguous, so the count of ones is the number of transfers
    always_comb begin
        push_cnt = '0;
        pop_cnt  = '0;
        for (int i = 0; i < M; i++) begin
            push_cnt = push_cnt + CNT_W'(push[i]);
        end
        for (int j = 0; j < N; j++) begin
            pop_cnt = pop_cnt + CNT_W'(pop[j]);
        end
    end

    assign free_cnt = CNT_W'(DEPTH) - count;
    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);

    // Lane i needs i+1 free or filled slots
    always_comb begin
        almost_full  = '0;
        almost_empty = '0;
        for (int i = 1; i < M; i++) begin
            almost_full[i] = (free_cnt < CNT_W'(i + 1));
        end
        for (int i = 1; i < N; i++) begin
            almost_empty[i] = (count < CNT_W'(i + 1));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wrap(wr_ptr, 32'(push_cnt));
            rd_ptr <= wrap(rd_ptr, 32'(pop_cnt));
            count  <= count + push_cnt - pop_cnt;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < M; i++) begin
            if (push[i]) begin
                mem[wrap(wr_ptr, i)] <= data_in[i];
            end
        end
    end

    // Heads in order, lane 0 is the oldest entry
    always_comb begin
        for (int j = 0; j < N; j++) begin
            data_out[j] = mem[wrap(rd_ptr, j)];
        end
    end

    push_lanes_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        (push & (push + M'(1))) == '0)
        else $error("multi_fifo push lanes not contiguous: %b", $sampled(push));

    pop_lanes_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        (pop & (pop + N'(1))) == '0)
        else $error("multi_fifo pop lanes not contiguous: %b", $sampled(pop));

    no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push_cnt <= free_cnt)
        else $error("multi_fifo push beyond free slots");

    no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop_cnt <= count)
        else $error("multi_fifo pop beyond stored entries");

endmodule

/* rtl/rvv_dispatch.sv */
module rvv_dispatch
    import rvv_cfg_pkg::*;
    import rvv_uop_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cq_empty,
    input  rvv_cmd_t              cq_data,
    output logic                  cq_pop,
    output logic [VREG_IDX_W-1:0] rd_idx_a,
    output logic [VREG_IDX_W-1:0] rd_idx_b,
    input  logic [VLEN-1:0]       rd_data_a,
    input  logic [VLEN-1:0]       rd_data_b,
    output logic                  uop_valid,
    output rvv_uop_t              uop,
    input  logic                  uop_ready,
    input  logic                  free_en,
    input  logic [VREG_IDX_W-1:0] free_idx
);

    logic [5:0]            funct6;
    logic [VREG_IDX_W-1:0] vs2;
    logic [VREG_IDX_W-1:0] vs1;
    logic [VREG_IDX_W-1:0] vd;
    alu_op_e               dec_op;
    logic                  dec_legal;
    logic [NUM_VREG-1:0]   busy;
    logic                  hazard;
    logic                  slot_free;
    logic                  dispatch;

    // Instruction fields of the queue head
    assign funct6 = cq_data.inst[31:26];
    assign vs2    = cq_data.inst[24:20];
    assign vs1    = cq_data.inst[19:15];
    assign vd     = cq_data.inst[11:7];

    always_comb begin
        dec_legal = 1'b1;
        case (funct6)
            FUNCT6_VADD:   dec_op = ALU_ADD;
            FUNCT6_VSUB:   dec_op = ALU_SUB;
            FUNCT6_VAND:   dec_op = ALU_AND;
            FUNCT6_VSADDU: dec_op = ALU_SADDU;
            default: begin
                dec_op    = ALU_ADD;
                dec_legal = 1'b0;
            end
        endcase
    end

    // Operands come straight from the register file
    assign rd_idx_a = vs2;
    assign rd_idx_b = vs1;

    // RAW and WAW both stall on the busy map
    assign hazard    = busy[vs2] | busy[vs1] | busy[vd];
    assign slot_free = !uop_valid || uop_ready;
    assign dispatch  = !cq_empty && dec_legal && !hazard && slot_free;

    // Unsupported heads are dropped right away
    assign cq_pop = dispatch || (!cq_empty && !dec_legal);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            uop_valid <= 1'b0;
        end else if (dispatch) begin
            uop_valid <= 1'b1;
        end else if (uop_ready) begin
            uop_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch) begin
            uop.op       <= dec_op;
            uop.vsew     <= cq_data.vsew;
            uop.vd       <= vd;
            uop.vs2_data <= rd_data_a;
            uop.vs1_data <= rd_data_b;
        end
    end

    // Set and clear never hit the same register in one cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (free_en) begin
                busy[free_idx] <= 1'b0;
            end
            if (dispatch) begin
                busy[vd] <= 1'b1;
            end
        end
    end

    free_only_busy: assert property (@(posedge clk) disable iff (!rst_n)
        free_en |-> busy[free_idx])
        else $error("retire freed v%0d which was not busy", $sampled(free_idx));

endmodule

/* rtl/rvv_vrf.sv */
module rvv_vrf
    import rvv_cfg_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [VREG_IDX_W-1:0] rd_idx_a,
    input  logic [VREG_IDX_W-1:0] rd_idx_b,
    output logic [VLEN-1:0]       rd_data_a,
    output logic [VLEN-1:0]       rd_data_b,
    input  logic                  wr_en,
    input  logic [VREG_IDX_W-1:0] wr_idx,
    input  logic [VLEN-1:0]       wr_data
);

    logic [VLEN-1:0] regs [NUM_VREG];

    // Known start state, every byte of vK holds K
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_VREG; k++) begin
                regs[k] <= {(VLEN / 8){8'(k)}};
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Reads see the register contents of this cycle
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

endmodule

/* rtl/rvv_alu.sv */
module rvv_alu
    import rvv_cfg_pkg::*;
    import rvv_uop_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        uop_valid,
    input  rvv_uop_t    uop,
    output logic        uop_ready,
    output logic        res_valid,
    output rvv_result_t res,
    input  logic        res_ready
);

    logic [VLEN-1:0] alu_data;
    logic            alu_sat;
    logic [32:0]     elem;

    // One element of width w, zero extended to 32 bits, flag in bit 32
    function automatic logic [32:0] elem_calc(alu_op_e op, logic [31:0] a, logic [31:0] b,
                                              int unsigned w);
        logic [32:0] sum;
        logic [32:0] ones;
        sum  = {1'b0, a} + {1'b0, b};
        ones = (33'd1 << w) - 33'd1;
        case (op)
            ALU_ADD: return {1'b0, sum[31:0]};
            ALU_SUB: return {1'b0, a - b};
            ALU_AND: return {1'b0, a & b};
            default: begin
                // Carry out of the element clamps to all ones
                if (sum[w]) begin
                    return {1'b1, ones[31:0]};
                end
                return {1'b0, sum[31:0]};
            end
        endcase
    endfunction

    always_comb begin
        alu_data = '0;
        alu_sat  = 1'b0;
        elem     = '0;
        case (uop.vsew)
            SEW8: begin
                for (int i = 0; i < VLEN / 8; i++) begin
                    elem = elem_calc(uop.op, 32'(uop.vs2_data[i*8 +: 8]),
                                     32'(uop.vs1_data[i*8 +: 8]), 8);
                    alu_data[i*8 +: 8] = elem[7:0];
                    alu_sat = alu_sat | elem[32];
                end
            end
            SEW16: begin
                for (int i = 0; i < VLEN / 16; i++) begin
                    elem = elem_calc(uop.op, 32'(uop.vs2_data[i*16 +: 16]),
                                     32'(uop.vs1_data[i*16 +: 16]), 16);
                    alu_data[i*16 +: 16] = elem[15:0];
                    alu_sat = alu_sat | elem[32];
                end
            end
            // 32-bit elements, also taken for the unused code
            default: begin
                for (int i = 0; i < VLEN / 32; i++) begin
                    elem = elem_calc(uop.op, uop.vs2_data[i*32 +: 32],
                                     uop.vs1_data[i*32 +: 32], 32);
                    alu_data[i*32 +: 32] = elem[31:0];
                    alu_sat = alu_sat | elem[32];
                end
            end
        endcase
    end

    // Output register holds while the result queue is full
    assign uop_ready = !res_valid || res_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (uop_valid && uop_ready) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (uop_valid && uop_ready) begin
            res.vd   <= uop.vd;
            res.data <= alu_data;
            res.sat  <= alu_sat;
        end
    end

endmodule

/* rtl/rvv_retire.sv */
module rvv_retire
    import rvv_cfg_pkg::*;
    import rvv_uop_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  rq_empty,
    input  rvv_result_t           rq_data,
    output logic                  rq_pop,
    output logic                  wr_en,
    output logic [VREG_IDX_W-1:0] wr_idx,
    output logic [VLEN-1:0]       wr_data,
    output logic                  free_en,
    output logic [VREG_IDX_W-1:0] free_idx,
    output logic                  rt_valid,
    output logic [VREG_IDX_W-1:0] rt_vd,
    output logic [VLEN-1:0]       rt_data,
    input  logic                  rt_ready,
    output logic                  vxsat
);

    // Head of the result queue is the oldest result
    assign rt_valid = !rq_empty;
    assign rt_vd    = rq_data.vd;
    assign rt_data  = rq_data.data;
    assign rq_pop   = rt_valid && rt_ready;

    // Architectural update on the retire transfer
    assign wr_en    = rq_pop;
    assign wr_idx   = rq_data.vd;
    assign wr_data  = rq_data.data;
    assign free_en  = rq_pop;
    assign free_idx = rq_data.vd;

    // Sticky until reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vxsat <= 1'b0;
        end else if (rq_pop && rq_data.sat) begin
            vxsat <= 1'b1;
        end
    end

endmodule

/* rtl/rvv_backend.sv */
module rvv_backend
    import rvv_cfg_pkg::*;
    import rvv_uop_pkg::*;
(
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic     [ISSUE_LANE-1:0]        cmd_valid,
    input  rvv_cmd_t [ISSUE_LANE-1:0]        cmd,
    output logic     [ISSUE_LANE-1:0]        cmd_ready,
    output logic                             rt_valid,
    output logic     [VREG_IDX_W-1:0]        rt_vd,
    output logic     [VLEN-1:0]              rt_data,
    input  logic                             rt_ready,
    output logic                             vxsat
);

    logic                  cq_full;
    logic [ISSUE_LANE-1:1] cq_almost_full;
    logic                  cq_empty;
    rvv_cmd_t              cq_data;
    logic                  cq_pop;
    logic [VREG_IDX_W-1:0] rd_idx_a;
    logic [VREG_IDX_W-1:0] rd_idx_b;
    logic [VLEN-1:0]       rd_data_a;
    logic [VLEN-1:0]       rd_data_b;
    logic                  uop_valid;
    rvv_uop_t              uop;
    logic                  uop_ready;
    logic                  res_valid;
    rvv_result_t           res;
    logic                  res_ready;
    logic                  rq_full;
    logic                  rq_empty;
    rvv_result_t           rq_data;
    logic                  rq_pop;
    logic                  wr_en;
    logic [VREG_IDX_W-1:0] wr_idx;
    logic [VLEN-1:0]       wr_data;
    logic                  free_en;
    logic [VREG_IDX_W-1:0] free_idx;

    // Lane i is ready only with more than i free slots
    always_comb begin
        cmd_ready[0] = !cq_full;
        for (int i = 1; i < ISSUE_LANE; i++) begin
            cmd_ready[i] = cmd_ready[i-1] && !cq_almost_full[i];
        end
    end

    multi_fifo #(
        .T     (rvv_cmd_t),
        .M     (ISSUE_LANE),
        .N     (1),
        .DEPTH (CQ_DEPTH)
    ) u_command_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .push         (cmd_valid & cmd_ready),
        .data_in      (cmd),
        .pop          (cq_pop),
        .data_out     (cq_data),
        .full         (cq_full),
        .almost_full  (cq_almost_full),
        .empty        (cq_empty),
        .almost_empty ()
    );

    rvv_dispatch u_dispatch (
        .clk       (clk),
        .rst_n     (rst_n),
        .cq_empty  (cq_empty),
        .cq_data   (cq_data),
        .cq_pop    (cq_pop),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .uop_valid (uop_valid),
        .uop       (uop),
        .uop_ready (uop_ready),
        .free_en   (free_en),
        .free_idx  (free_idx)
    );

    rvv_vrf u_vrf (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data)
    );

    rvv_alu u_alu (
        .clk       (clk),
        .rst_n     (rst_n),
        .uop_valid (uop_valid),
        .uop       (uop),
        .uop_ready (uop_ready),
        .res_valid (res_valid),
        .res       (res),
        .res_ready (res_ready)
    );

    // Full result queue stalls the ALU
    assign res_ready = !rq_full;

    multi_fifo #(
        .T     (rvv_result_t),
        .M     (1),
        .N     (1),
        .DEPTH (RQ_DEPTH)
    ) u_result_queue (
        .clk          (clk),
        .rst_n        (rst_n),
        .push         (res_valid & res_ready),
        .data_in      (res),
        .pop          (rq_pop),
        .data_out     (rq_data),
        .full         (rq_full),
        .almost_full  (),
        .empty        (rq_empty),
        .almost_empty ()
    );

    rvv_retire u_retire (
        .clk      (clk),
        .rst_n    (rst_n),
        .rq_empty (rq_empty),
        .rq_data  (rq_data),
        .rq_pop   (rq_pop),
        .wr_en    (wr_en),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .free_en  (free_en),
        .free_idx (free_idx),
        .rt_valid (rt_valid),
        .rt_vd    (rt_vd),
        .rt_data  (rt_data),
        .rt_ready (rt_ready),
        .vxsat    (vxsat)
    );

endmodule

/* dv/tb_rvv_backend.sv */
module tb_rvv_backend
    import rvv_cfg_pkg::*;
    import rvv_uop_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 10;
    localparam int N_CMDS          = 200;
    localparam int IDLE_CYCLES     = 20;
    localparam int WATCHDOG_CYCLES = N_CMDS * 20;

    logic                             clk;
    logic                             rst_n;
    logic     [ISSUE_LANE-1:0]        cmd_valid;
    rvv_cmd_t [ISSUE_LANE-1:0]        cmd;
    logic     [ISSUE_LANE-1:0]        cmd_ready;
    logic                             rt_valid;
    logic     [VREG_IDX_W-1:0]        rt_vd;
    logic     [VLEN-1:0]              rt_data;
    logic                             rt_ready;
    logic                             vxsat;

    integer          seed;
    rvv_cmd_t        stream [N_CMDS];
    logic [VLEN-1:0] model_vrf [NUM_VREG];
    rvv_result_t     exp_q [$];
    rvv_result_t     exp_head;
    int              exp_count;
    logic            exp_vxsat;
    int              legal_cnt;
    int              illegal_cnt;
    int              retired_cnt;
    int              next_cmd;
    int              shown;
    int              pending;
    int              taken;
    int              cyc;
    logic            retire_seen;

    rvv_backend u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .cmd_ready (cmd_ready),
        .rt_valid  (rt_valid),
        .rt_vd     (rt_vd),
        .rt_data   (rt_data),
        .rt_ready  (rt_ready),
        .vxsat     (vxsat)
    );

    task automatic stop_run(string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    function automatic int rand_below(int unsigned n);
        int unsigned r;
        r = $unsigned($random(seed));
        return int'(r % n);
    endfunction

    function automatic logic is_legal(logic [5:0] f6);
        return f6 inside {FUNCT6_VADD, FUNCT6_VSUB, FUNCT6_VAND, FUNCT6_VSADDU};
    endfunction

    // Small register window most of the time, so hazards are frequent
    function automatic rvv_cmd_t make_cmd();
        rvv_cmd_t   c;
        int         span;
        int         sel;
        logic [5:0] f6;
        logic [4:0] vs2;
        logic [4:0] vs1;
        logic [4:0] vd;
        span = (rand_below(4) == 0) ? NUM_VREG : 6;
        vs2  = 5'(rand_below(span));
        vs1  = 5'(rand_below(span));
        vd   = 5'(rand_below(span));
        sel  = rand_below(10);
        if (sel == 9) begin
            f6 = 6'(rand_below(64));
            if (is_legal(f6)) begin
                f6 = 6'b111111;
            end
        end else begin
            case (sel % 4)
                0:       f6 = FUNCT6_VADD;
                1:       f6 = FUNCT6_VSUB;
                2:       f6 = FUNCT6_VAND;
                default: f6 = FUNCT6_VSADDU;
            endcase
        end
        // OPIVV form, vm set
        c.inst = {f6, 1'b1, vs2, vs1, 3'b000, vd, 7'b1010111};
        c.vsew = vsew_e'(rand_below(3));
        return c;
    endfunction

    // Sequential reference execution on the model register file
    function automatic rvv_result_t model_exec(rvv_cmd_t c);
        rvv_result_t     r;
        logic [VLEN-1:0] a;
        logic [VLEN-1:0] b;
        longint unsigned ea;
        longint unsigned eb;
        longint unsigned er;
        longint unsigned emax;
        int              w;
        a    = model_vrf[c.inst[24:20]];
        b    = model_vrf[c.inst[19:15]];
        w    = (c.vsew == SEW8) ? 8 : (c.vsew == SEW16) ? 16 : 32;
        emax = (64'd1 << w) - 64'd1;
        r.vd   = c.inst[11:7];
        r.data = '0;
        r.sat  = 1'b0;
        for (int i = 0; i < VLEN / w; i++) begin
            ea = 64'(a >> (i * w)) & emax;
            eb = 64'(b >> (i * w)) & emax;
            case (c.inst[31:26])
                FUNCT6_VADD: er = ea + eb;
                FUNCT6_VSUB: er = ea - eb;
                FUNCT6_VAND: er = ea & eb;
                default: begin
                    er = ea + eb;
                    if (er > emax) begin
                        er    = emax;
                        r.sat = 1'b1;
                    end
                end
            endcase
            r.data = r.data | (VLEN'(er & emax) << (i * w));
        end
        return r;
    endfunction

    task automatic accept_cmd(rvv_cmd_t c);
        rvv_result_t r;
        if (is_legal(c.inst[31:26])) begin
            r = model_exec(c);
            model_vrf[r.vd] = r.data;
            exp_q.push_back(r);
            legal_cnt++;
        end else begin
            illegal_cnt++;
        end
    endtask

    task automatic refresh_head();
        exp_count = exp_q.size();
        exp_head  = (exp_count > 0) ? exp_q[0] : '0;
    endtask

    // Lanes not yet accepted stay on, lane 0 first
    task automatic drive_inputs();
        int want;
        want = rand_below(3);
        if (want < pending) begin
            want = pending;
        end
        if (want > N_CMDS - next_cmd) begin
            want = N_CMDS - next_cmd;
        end
        shown     = want;
        cmd_valid = '0;
        cmd       = '0;
        for (int i = 0; i < want; i++) begin
            cmd_valid[i] = 1'b1;
            cmd[i]       = stream[next_cmd + i];
        end
        // Long stall phases back up both queues
        if ((cyc / 64) % 2 == 1) begin
            rt_ready = (rand_below(5) == 0);
        end else begin
            rt_ready = (rand_below(4) != 0);
        end
        cyc++;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_run("Timeout: the expected results did not all retire in time");
    end

    // Every transfer on the retire port, idle phase included
    always @(posedge clk) begin
        if (rst_n && rt_valid && rt_ready) begin
            retired_cnt++;
        end
    end

    reset_state: assert property (@(posedge clk)
        $rose(rst_n) |-> !rt_valid && !vxsat && cmd_ready[0])
        else stop_run($sformatf("FAILED at %0t: outputs not idle after reset", $time));

    lane_ready_order: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_ready[1] |-> cmd_ready[0])
        else stop_run($sformatf("FAILED at %0t: cmd_ready[1] high without lane 0", $time));

    retire_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && rt_ready |-> rt_vd == exp_head.vd && rt_data == exp_head.data)
        else stop_run($sformatf("FAILED at %0t: retired v%0d %h, expected v%0d %h", $time,
                                $sampled(rt_vd), $sampled(rt_data), exp_head.vd,
                                exp_head.data));

    no_unexpected_retire: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid |-> exp_count > 0)
        else stop_run($sformatf("FAILED at %0t: rt_valid with no result expected", $time));

    retire_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && !rt_ready |=> rt_valid && $stable(rt_vd) && $stable(rt_data))
        else stop_run($sformatf("FAILED at %0t: retire port changed while stalled", $time));

    vxsat_matches_model: assert property (@(posedge clk) disable iff (!rst_n)
        vxsat == exp_vxsat)
        else stop_run($sformatf("FAILED at %0t: vxsat is %b, expected %b", $time,
                                $sampled(vxsat), exp_vxsat));

    vxsat_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        vxsat |=> vxsat)
        else stop_run($sformatf("FAILED at %0t: vxsat dropped", $time));

    initial begin
        seed        = 48;
        rst_n       = 1'b0;
        cmd_valid   = '0;
        cmd         = '0;
        rt_ready    = 1'b0;
        exp_vxsat   = 1'b0;
        legal_cnt   = 0;
        illegal_cnt = 0;
        retired_cnt = 0;
        next_cmd    = 0;
        shown       = 0;
        pending     = 0;
        cyc         = 0;
        retire_seen = 1'b0;
        for (int k = 0; k < NUM_VREG; k++) begin
            model_vrf[k] = {(VLEN / 8){8'(k)}};
        end
        for (int n = 0; n < N_CMDS; n++) begin
            stream[n] = make_cmd();
        end
        refresh_head();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (!(next_cmd == N_CMDS && exp_q.size() == 0)) begin
            @(posedge clk);
            #1;
            if (retire_seen && exp_q.size() > 0) begin
                exp_vxsat = exp_vxsat | exp_q[0].sat;
                void'(exp_q.pop_front());
                refresh_head();
            end
            drive_inputs();
            // Handshakes are settled by mid cycle
            @(negedge clk);
            taken = 0;
            for (int i = 0; i < ISSUE_LANE; i++) begin
                if (cmd_valid[i] && cmd_ready[i]) begin
                    accept_cmd(cmd[i]);
                    taken++;
                end
            end
            refresh_head();
            next_cmd    = next_cmd + taken;
            pending     = shown - taken;
            retire_seen = rt_valid && rt_ready;
        end
        @(posedge clk);
        #1;
        cmd_valid = '0;
        rt_ready  = 1'b1;
        // Dropped commands must not show up late
        repeat (IDLE_CYCLES) @(posedge clk);
        #1;
        $display("retired %0d results, %0d unsupported commands dropped",
                 retired_cnt, illegal_cnt);
        if (retired_cnt == legal_cnt) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_run($sformatf("FAILED at %0t: retired %0d results for %0d legal commands",
                               $time, retired_cnt, legal_cnt));
        end
    end

endmodule

/* verilog.f */
rtl/rvv_cfg_pkg.sv
rtl/rvv_uop_pkg.sv
rtl/multi_fifo.sv
rtl/rvv_dispatch.sv
rtl/rvv_vrf.sv
rtl/rvv_alu.sv
rtl/rvv_retire.sv
rtl/rvv_backend.sv
dv/tb_rvv_backend.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_rvv_backend -f verilog.f \
    -o sim_rvv_backend > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_rvv_backend > sim.log 2>&1 || true
cat sim.log
grep -q "^STATUS: PASS$" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
